// ==== block_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_sequencer #(
	parameter int n_blocks = 16
) (
	input  logic clk,
	input  logic full_reset,
	input  logic enable,
	input  logic tick,
	input  logic resetting,
	input  logic [$clog2(n_blocks) : 0] n_running,

	output logic [$clog2(n_blocks) - 1 : 0] instr_addr,
	input  dsp_pkg::instr_t instr,
	input  logic done,

	output logic issue,
	output logic [$clog2(n_blocks) - 1 : 0] block,
	output logic op,
	output dsp_pkg::chan_addr_t src_a,
	output dsp_pkg::chan_addr_t src_b,
	output dsp_pkg::chan_addr_t src_c,
	output logic a_reg,
	output logic b_reg,
	output logic c_reg,
	output dsp_pkg::chan_addr_t dest,
	output dsp_pkg::shift_t shift,
	output logic sat_disable
);
	import dsp_pkg::*;

	seq_state_t state;
	logic done_pending;	// Done seen while paused or before the execute state.
	logic [$clog2(n_blocks) : 0] blocks_done;

	assign blocks_done = {1'b0, block} + 1'b1;

	// While waiting for done the next instruction is already read.
	assign instr_addr = (state == seq_execute) ? block + 1'b1 : block;
	assign issue      = (state == seq_decode) && enable;

	assign op          = instr[op_bit];
	assign src_a       = instr[src_a_lsb +: $bits(chan_addr_t)];
	assign a_reg       = instr[a_reg_bit];
	assign src_b       = instr[src_b_lsb +: $bits(chan_addr_t)];
	assign b_reg       = instr[b_reg_bit];
	assign src_c       = instr[src_c_lsb +: $bits(chan_addr_t)];
	assign c_reg       = instr[c_reg_bit];
	assign dest        = instr[dest_lsb +: $bits(chan_addr_t)];
	assign shift       = instr[shift_lsb +: $bits(shift_t)];
	assign sat_disable = instr[sat_disable_bit];

	always_ff @(posedge clk) begin
		if (full_reset || resetting) begin
			state        <= seq_idle;
			block        <= '0;
			done_pending <= 1'b0;
		end else begin
			if (done)
				done_pending <= 1'b1;

			if (enable) begin
				case (state)
					seq_idle: begin
						if (tick && n_running != '0) begin
							block <= '0;
							state <= seq_fetch;
						end
					end
					seq_fetch:   state <= seq_decode;
					seq_decode:  state <= seq_operand;
					seq_operand: state <= seq_execute;
					seq_execute: begin
						if (done || done_pending) begin
							done_pending <= 1'b0;
							if (blocks_done == n_running) begin
								state <= seq_idle;	// Last running block finished.
							end else begin
								block <= block + 1'b1;
								state <= seq_decode;
							end
						end
					end
					default: state <= seq_idle;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== channel_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_file (
	input  logic clk,
	input  logic resetting,
	input  logic tick,

	input  dsp_pkg::sample_t sample_in,
	output dsp_pkg::sample_t sample_out,

	input  dsp_pkg::chan_addr_t chan_read_addr,
	output dsp_pkg::sample_t chan_read_val,

	input  logic chan_write,
	input  dsp_pkg::chan_addr_t chan_write_addr,
	input  dsp_pkg::sample_t chan_write_val
);
	import dsp_pkg::*;

	sample_t channels [n_channels];

	// ********************
	// Channel registers
	// ********************

	always_ff @(posedge clk) begin
		if (resetting) begin
			for (int i = 0; i < n_channels; i++)
				channels[i] <= '0;
		end else begin
			if (chan_write)
				channels[chan_write_addr] <= chan_write_val;
			if (tick)
				channels[0] <= sample_in;	// Takes priority over the program write.
		end
		chan_read_val <= channels[chan_read_addr];
	end

	// Channel 0 leaves on the same edge that the new sample enters.
	always_ff @(posedge clk) begin
		if (tick && !resetting)
			sample_out <= channels[0];
	end

endmodule

`default_nettype wire

// ==== dsp_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_core #(
	parameter int n_blocks = 16
) (
	input  logic clk,
	input  logic full_reset,

	input  logic enable,
	input  logic tick,

	input  dsp_pkg::sample_t sample_in,
	output dsp_pkg::sample_t sample_out,

	output logic ready,
	output logic resetting,

	input  logic command_instr_write,
	input  logic command_reg_write,
	input  logic [$clog2(n_blocks) - 1 : 0] command_block_target,
	input  dsp_pkg::reg_sel_t command_reg_target,
	input  dsp_pkg::instr_t   command_instr_write_val,
	input  dsp_pkg::sample_t  command_reg_write_val
);
	import dsp_pkg::*;

	localparam int block_w = $clog2(n_blocks);

	logic [block_w - 1 : 0] instr_addr;
	instr_t                 instr;
	logic [block_w : 0]     coef_addr;
	sample_t                coef;
	logic [block_w : 0]     n_running;

	// Decoded instruction, valid while issue is high.
	logic                   issue;
	logic [block_w - 1 : 0] block;
	logic                   op;
	chan_addr_t             src_a;
	chan_addr_t             src_b;
	chan_addr_t             src_c;
	logic                   a_reg;
	logic                   b_reg;
	logic                   c_reg;
	chan_addr_t             dest;
	shift_t                 shift;
	logic                   sat_disable;

	chan_addr_t chan_read_addr;
	sample_t    chan_read_val;

	logic       args_valid;
	sample_t    arg_a;
	sample_t    arg_b;
	sample_t    arg_c;
	logic       args_op;
	chan_addr_t args_dest;
	shift_t     args_shift;
	logic       args_sat_disable;

	logic       chan_write;
	chan_addr_t chan_write_addr;
	sample_t    chan_write_val;
	logic       done;

	program_store #(.n_blocks(n_blocks)) program_store_inst (
		.clk                     (clk),
		.full_reset              (full_reset),
		.instr_write             (command_instr_write),
		.reg_write               (command_reg_write),
		.command_block_target    (command_block_target),
		.command_reg_target      (command_reg_target),
		.command_instr_write_val (command_instr_write_val),
		.command_reg_write_val   (command_reg_write_val),
		.instr_addr              (instr_addr),
		.instr                   (instr),
		.coef_addr               (coef_addr),
		.coef                    (coef),
		.n_running               (n_running),
		.ready                   (ready),
		.resetting               (resetting)
	);

	block_sequencer #(.n_blocks(n_blocks)) block_sequencer_inst (
		.clk         (clk),
		.full_reset  (full_reset),
		.enable      (enable),
		.tick        (tick),
		.resetting   (resetting),
		.n_running   (n_running),
		.instr_addr  (instr_addr),
		.instr       (instr),
		.done        (done),
		.issue       (issue),
		.block       (block),
		.op          (op),
		.src_a       (src_a),
		.src_b       (src_b),
		.src_c       (src_c),
		.a_reg       (a_reg),
		.b_reg       (b_reg),
		.c_reg       (c_reg),
		.dest        (dest),
		.shift       (shift),
		.sat_disable (sat_disable)
	);

	operand_fetch #(.n_blocks(n_blocks)) operand_fetch_inst (
		.clk              (clk),
		.full_reset       (full_reset),
		.issue            (issue),
		.block            (block),
		.op               (op),
		.src_a            (src_a),
		.src_b            (src_b),
		.src_c            (src_c),
		.a_reg            (a_reg),
		.b_reg            (b_reg),
		.c_reg            (c_reg),
		.dest             (dest),
		.shift            (shift),
		.sat_disable      (sat_disable),
		.chan_read_addr   (chan_read_addr),
		.chan_read_val    (chan_read_val),
		.coef_addr        (coef_addr),
		.coef             (coef),
		.args_valid       (args_valid),
		.arg_a            (arg_a),
		.arg_b            (arg_b),
		.arg_c            (arg_c),
		.args_op          (args_op),
		.args_dest        (args_dest),
		.args_shift       (args_shift),
		.args_sat_disable (args_sat_disable)
	);

	madd_unit madd_unit_inst (
		.clk             (clk),
		.full_reset      (full_reset),
		.args_valid      (args_valid),
		.arg_a           (arg_a),
		.arg_b           (arg_b),
		.arg_c           (arg_c),
		.op              (args_op),
		.dest            (args_dest),
		.shift           (args_shift),
		.sat_disable     (args_sat_disable),
		.chan_write      (chan_write),
		.chan_write_addr (chan_write_addr),
		.chan_write_val  (chan_write_val),
		.done            (done)
	);

	channel_file channel_file_inst (
		.clk             (clk),
		.resetting       (resetting),
		.tick            (tick),
		.sample_in       (sample_in),
		.sample_out      (sample_out),
		.chan_read_addr  (chan_read_addr),
		.chan_read_val   (chan_read_val),
		.chan_write      (chan_write),
		.chan_write_addr (chan_write_addr),
		.chan_write_val  (chan_write_val)
	);

endmodule

`default_nettype wire

// ==== dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

	// ********************
	// Widths and types
	// ********************

	localparam int sample_width = 16;
	localparam int frac_bits    = 14;	// Q2.14 samples and coefficients.
	localparam int n_channels   = 16;

	typedef logic signed [sample_width - 1 : 0]     sample_t;
	typedef logic signed [2 * sample_width - 1 : 0] product_t;
	typedef logic [31 : 0]                          instr_t;
	typedef logic [$clog2(n_channels) - 1 : 0]      chan_addr_t;
	typedef logic                                   reg_sel_t;
	typedef logic [4 : 0]                           shift_t;

	localparam product_t sample_max = product_t'(2 ** (sample_width - 1) - 1);
	localparam product_t sample_min = product_t'(-(2 ** (sample_width - 1)));

	// ********************
	// Instruction fields
	// ********************

	localparam int op_bit          = 0;	// 1 is madd, 0 is nop.
	localparam int src_a_lsb       = 1;
	localparam int a_reg_bit       = 5;
	localparam int src_b_lsb       = 6;
	localparam int b_reg_bit       = 10;
	localparam int src_c_lsb       = 11;
	localparam int c_reg_bit       = 15;
	localparam int dest_lsb        = 16;
	localparam int shift_lsb       = 20;
	localparam int sat_disable_bit = 25;

	// Operand codes, valid when the reg flag of the operand is set.
	localparam chan_addr_t src_coef0   = chan_addr_t'(0);
	localparam chan_addr_t src_coef1   = chan_addr_t'(1);
	localparam chan_addr_t src_pos_one = chan_addr_t'(2);
	localparam chan_addr_t src_neg_one = chan_addr_t'(3);

	localparam sample_t const_pos_one = sample_t'(2 ** frac_bits);
	localparam sample_t const_neg_one = sample_t'(-(2 ** (sample_width - 1)));	// -2.0

	typedef enum logic [2 : 0] {
		seq_idle,
		seq_fetch,
		seq_decode,
		seq_operand,
		seq_execute
	} seq_state_t;

endpackage

`default_nettype wire

// ==== madd_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module madd_unit (
	input  logic clk,
	input  logic full_reset,

	input  logic args_valid,
	input  dsp_pkg::sample_t arg_a,
	input  dsp_pkg::sample_t arg_b,
	input  dsp_pkg::sample_t arg_c,
	input  logic op,
	input  dsp_pkg::chan_addr_t dest,
	input  dsp_pkg::shift_t shift,
	input  logic sat_disable,

	output logic chan_write,
	output dsp_pkg::chan_addr_t chan_write_addr,
	output dsp_pkg::sample_t chan_write_val,
	output logic done
);
	import dsp_pkg::*;

	product_t product;
	product_t scaled;
	product_t sum;
	sample_t  result;

	assign product = product_t'(arg_a) * product_t'(arg_b);
	assign scaled  = (product >>> frac_bits) <<< shift;	// Back to Q2.14, then scaled up.
	assign sum     = scaled + product_t'(arg_c);

	always_comb begin
		if (sat_disable)
			result = sample_t'(sum);	// Wraps to the low bits.
		else if (sum > sample_max)
			result = sample_t'(sample_max);
		else if (sum < sample_min)
			result = sample_t'(sample_min);
		else
			result = sample_t'(sum);
	end

	always_ff @(posedge clk) begin
		if (full_reset) begin
			chan_write <= 1'b0;
			done       <= 1'b0;
		end else begin
			chan_write <= args_valid && op;
			done       <= args_valid;	// A nop still completes its block.
		end
		chan_write_addr <= dest;
		chan_write_val  <= result;
	end

endmodule

`default_nettype wire

// ==== operand_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_fetch #(
	parameter int n_blocks = 16
) (
	input  logic clk,
	input  logic full_reset,

	input  logic issue,
	input  logic [$clog2(n_blocks) - 1 : 0] block,
	input  logic op,
	input  dsp_pkg::chan_addr_t src_a,
	input  dsp_pkg::chan_addr_t src_b,
	input  dsp_pkg::chan_addr_t src_c,
	input  logic a_reg,
	input  logic b_reg,
	input  logic c_reg,
	input  dsp_pkg::chan_addr_t dest,
	input  dsp_pkg::shift_t shift,
	input  logic sat_disable,

	output dsp_pkg::chan_addr_t chan_read_addr,
	input  dsp_pkg::sample_t chan_read_val,
	output logic [$clog2(n_blocks) : 0] coef_addr,
	input  dsp_pkg::sample_t coef,

	output logic args_valid,
	output dsp_pkg::sample_t arg_a,
	output dsp_pkg::sample_t arg_b,
	output dsp_pkg::sample_t arg_c,
	output logic args_op,
	output dsp_pkg::chan_addr_t args_dest,
	output dsp_pkg::shift_t args_shift,
	output logic args_sat_disable
);
	import dsp_pkg::*;

	logic slot_b;	// Reading operand b, data for a returns.
	logic slot_c;	// Reading operand c, data for b returns.

	logic [$clog2(n_blocks) - 1 : 0] block_q;
	chan_addr_t src_b_q;
	chan_addr_t src_c_q;
	logic       b_reg_q;
	logic       c_reg_q;

	chan_addr_t slot_src;
	logic       slot_reg;
	chan_addr_t rd_src;
	logic       rd_reg;
	sample_t    resolved;

	always_comb begin
		if (slot_b) begin
			slot_src = src_b_q;
			slot_reg = b_reg_q;
		end else if (slot_c) begin
			slot_src = src_c_q;
			slot_reg = c_reg_q;
		end else begin
			slot_src = src_a;
			slot_reg = a_reg;
		end
	end

	assign chan_read_addr = slot_src;
	assign coef_addr      = {(issue ? block : block_q), slot_src[0]};

	// Resolve the operand whose read was issued on the previous cycle.
	always_comb begin
		if (!rd_reg) begin
			resolved = chan_read_val;
		end else begin
			case (rd_src)
				src_coef0, src_coef1: resolved = coef;
				src_pos_one:          resolved = const_pos_one;
				src_neg_one:          resolved = const_neg_one;
				default:              resolved = '0;
			endcase
		end
	end

	assign arg_c = resolved;	// Arrives in the args_valid cycle.

	always_ff @(posedge clk) begin
		if (full_reset) begin
			slot_b     <= 1'b0;
			slot_c     <= 1'b0;
			args_valid <= 1'b0;
		end else begin
			slot_b     <= issue;
			slot_c     <= slot_b;
			args_valid <= slot_c;
		end
	end

	always_ff @(posedge clk) begin
		rd_src <= slot_src;
		rd_reg <= slot_reg;
		if (issue) begin
			block_q          <= block;
			src_b_q          <= src_b;
			src_c_q          <= src_c;
			b_reg_q          <= b_reg;
			c_reg_q          <= c_reg;
			args_op          <= op;
			args_dest        <= dest;
			args_shift       <= shift;
			args_sat_disable <= sat_disable;
		end
		if (slot_b)
			arg_a <= resolved;
		if (slot_c)
			arg_b <= resolved;
	end

endmodule

`default_nettype wire

// ==== program_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_store #(
	parameter int n_blocks = 16
) (
	input  logic clk,
	input  logic full_reset,

	input  logic instr_write,
	input  logic reg_write,
	input  logic [$clog2(n_blocks) - 1 : 0] command_block_target,
	input  dsp_pkg::reg_sel_t command_reg_target,
	input  dsp_pkg::instr_t   command_instr_write_val,
	input  dsp_pkg::sample_t  command_reg_write_val,

	input  logic [$clog2(n_blocks) - 1 : 0] instr_addr,
	output dsp_pkg::instr_t instr,

	input  logic [$clog2(n_blocks) : 0] coef_addr,
	output dsp_pkg::sample_t coef,

	output logic [$clog2(n_blocks) : 0] n_running,
	output logic ready,
	output logic resetting
);
	import dsp_pkg::*;

	localparam int block_w = $clog2(n_blocks);
	localparam logic [block_w - 1 : 0] last_block = block_w'(n_blocks - 1);

	instr_t  instr_mem [n_blocks];
	sample_t coef_mem  [2 * n_blocks];	// Two registers per block.

	logic [block_w - 1 : 0] clear_ctr;

	logic                   instr_we;
	logic [block_w - 1 : 0] instr_waddr;
	instr_t                 instr_wval;

	// The clear sequence takes over the instruction write port.
	assign instr_we    = resetting || instr_write;
	assign instr_waddr = resetting ? clear_ctr : command_block_target;
	assign instr_wval  = resetting ? '0 : command_instr_write_val;

	// ********************
	// Clear sequence and block count
	// ********************

	always_ff @(posedge clk) begin
		if (full_reset) begin
			resetting <= 1'b1;
			ready     <= 1'b0;
			clear_ctr <= '0;
			n_running <= '0;
		end else begin
			if (resetting) begin
				clear_ctr <= clear_ctr + 1'b1;
				if (clear_ctr == last_block) begin
					resetting <= 1'b0;
					ready     <= 1'b1;
				end
			end else if (instr_write && {1'b0, command_block_target} >= n_running) begin
				n_running <= {1'b0, command_block_target} + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instr_we)
			instr_mem[instr_waddr] <= instr_wval;
		instr <= instr_mem[instr_addr];
	end

	always_ff @(posedge clk) begin
		if (reg_write)
			coef_mem[{command_block_target, command_reg_target}] <= command_reg_write_val;
		coef <= coef_mem[coef_addr];
	end

endmodule

`default_nettype wire

// ==== project.f ====
dsp_pkg.sv
channel_file.sv
madd_unit.sv
operand_fetch.sv
block_sequencer.sv
program_store.sv
dsp_core.sv
tb_clock_gen.sv
tb_dsp_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the dsp_core testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f project.f --top-module tb_dsp_core -o tb_dsp_core_sim \
	&& ./obj_dir/tb_dsp_core_sim | tee sim.log \
	|| { echo "Build or simulation error"; exit 1; }

grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int half_period = 50	// Half of the 100 ns period.
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== tb_dsp_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_core;

	localparam int n_blocks          = 16;
	localparam int clk_period        = 100;
	localparam int n_rand_programs   = 4;
	localparam int n_pause_programs  = 2;
	localparam int ticks_per_program = 8;
	localparam int total_ticks       = 16 + (n_rand_programs + n_pause_programs) * ticks_per_program;
	localparam int max_tick_cycles   = 5 * n_blocks + 20 + 16;	// Longest run, gap and pause.
	localparam int setup_cycles      = (n_rand_programs + 2) * 3 * n_blocks + 2 * (n_blocks + 14);
	localparam int watchdog_cycles   = total_ticks * max_tick_cycles + setup_cycles + 500;

	logic               clk;
	logic               full_reset;
	logic               enable;
	logic               tick;
	logic signed [15:0] sample_in;
	logic signed [15:0] sample_out;
	logic               ready;
	logic               resetting;
	logic               command_instr_write;
	logic               command_reg_write;
	logic [3:0]         command_block_target;
	logic               command_reg_target;
	logic [31:0]        command_instr_write_val;
	logic signed [15:0] command_reg_write_val;

	logic [31:0] lfsr_state;

	// Reference model state.
	logic [31:0]        model_prog [n_blocks];
	logic signed [15:0] model_coef [n_blocks][2];
	logic signed [15:0] model_ch [16];
	int                 model_running;

	logic signed [15:0] last_out;
	int                 check_count;
	int                 error_count;

	tb_clock_gen clock_gen_inst (.clk(clk));

	dsp_core #(.n_blocks(n_blocks)) dsp_core_inst (
		.clk                     (clk),
		.full_reset              (full_reset),
		.enable                  (enable),
		.tick                    (tick),
		.sample_in               (sample_in),
		.sample_out              (sample_out),
		.ready                   (ready),
		.resetting               (resetting),
		.command_instr_write     (command_instr_write),
		.command_reg_write       (command_reg_write),
		.command_block_target    (command_block_target),
		.command_reg_target      (command_reg_target),
		.command_instr_write_val (command_instr_write_val),
		.command_reg_write_val   (command_reg_write_val)
	);

	// ********************
	// Random numbers
	// ********************

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int n_bits);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n_bits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// Spare bits 31:26 stay random, the decoder must ignore them.
	function automatic logic [31:0] random_instr();
		logic [31:0] word;
		word = random_bits(32);
		word[0] = (random_bits(3) != 0);	// Mostly madd.
		for (int k = 0; k < 3; k++) begin
			if (word[5 + 5 * k])
				word[1 + 5 * k +: 4] = 4'(random_bits(3));	// Codes 0 to 7.
		end
		if (random_bits(1) != 0)
			word[24:20] = 5'(random_bits(2));
		return word;
	endfunction

	// Madd with all three operands taken from register codes, result to channel 0.
	function automatic logic [31:0] reg_madd(input logic [3:0] a, input logic [3:0] b,
		input logic [3:0] c, input logic no_sat);
		return {6'd0, no_sat, 5'd0, 4'd0, 1'b1, c, 1'b1, b, 1'b1, a, 1'b1};
	endfunction

	// ********************
	// Reference model
	// ********************

	function automatic logic signed [15:0] operand_value(input logic [3:0] src,
		input logic is_reg, input int blk);
		if (!is_reg)
			return model_ch[src];
		case (src)
			4'd0:    return model_coef[blk][0];
			4'd1:    return model_coef[blk][1];
			4'd2:    return 16'sh4000;	// +1.0
			4'd3:    return 16'sh8000;	// -2.0
			default: return 16'sh0000;
		endcase
	endfunction

	function automatic logic signed [15:0] madd_result(input logic signed [15:0] a,
		input logic signed [15:0] b, input logic signed [15:0] c, input logic [4:0] sh,
		input logic no_sat);
		int prod;
		int total;
		prod  = int'(a) * int'(b);
		prod  = prod >>> 14;
		prod  = prod << sh;
		total = prod + int'(c);
		if (no_sat)
			return total[15:0];
		if (total > 32767)
			return 16'sh7fff;
		if (total < -32768)
			return 16'sh8000;
		return total[15:0];
	endfunction

	function automatic void run_model(input logic signed [15:0] sample);
		logic [31:0]        w;
		logic signed [15:0] a;
		logic signed [15:0] b;
		logic signed [15:0] c;
		model_ch[0] = sample;
		for (int blk = 0; blk < model_running; blk++) begin
			w = model_prog[blk];
			if (w[0]) begin
				a = operand_value(w[4:1], w[5], blk);
				b = operand_value(w[9:6], w[10], blk);
				c = operand_value(w[14:11], w[15], blk);
				model_ch[w[19:16]] = madd_result(a, b, c, w[24:20], w[25]);
			end
		end
	endfunction

	function automatic void compare_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("ERROR: %s = %h, expected %h", name, actual, expected);
		end
	endfunction

	// ********************
	// Stimulus tasks
	// ********************

	task automatic write_instr(input logic [3:0] blk, input logic [31:0] word);
		command_instr_write     = 1'b1;
		command_block_target    = blk;
		command_instr_write_val = word;
		model_prog[blk] = word;
		if (int'(blk) >= model_running)
			model_running = int'(blk) + 1;
		@(negedge clk);
		command_instr_write = 1'b0;
	endtask

	task automatic write_coef(input logic [3:0] blk, input logic sel,
		input logic signed [15:0] value);
		command_reg_write     = 1'b1;
		command_block_target  = blk;
		command_reg_target    = sel;
		command_reg_write_val = value;
		model_coef[blk][sel] = value;
		@(negedge clk);
		command_reg_write = 1'b0;
	endtask

	task automatic random_coefs();
		for (int blk = 0; blk < n_blocks; blk++) begin
			write_coef(4'(blk), 1'b0, 16'(random_bits(16)));
			write_coef(4'(blk), 1'b1, 16'(random_bits(16)));
		end
	endtask

	task automatic apply_reset();
		int cycles;
		full_reset = 1'b1;
		@(negedge clk);
		compare_value("resetting", 16'(resetting), 16'h0001);
		compare_value("ready", 16'(ready), 16'h0000);
		repeat (9) @(negedge clk);
		full_reset = 1'b0;
		cycles = 0;
		while (ready !== 1'b1 && cycles < n_blocks + 4) begin
			@(negedge clk);
			cycles++;
		end
		check_count++;
		assert (ready === 1'b1) else begin
			error_count++;
			$display("ready did not return within %0d cycles of releasing full_reset.",
				n_blocks + 4);
		end
		compare_value("resetting", 16'(resetting), 16'h0000);
		for (int i = 0; i < n_blocks; i++)
			model_prog[i] = '0;
		for (int i = 0; i < 16; i++)
			model_ch[i] = '0;
		model_running = 0;	// Coefficients survive the clear.
	endtask

	// One tick, then the gap for the run. A nonzero pause_len drops enable mid run.
	task automatic tick_and_check(input logic signed [15:0] sample, input int pause_at,
		input int pause_len);
		logic signed [15:0] expected;
		int                 gap;
		gap      = 5 * model_running + 20;
		expected = model_ch[0];
		run_model(sample);
		tick      = 1'b1;
		sample_in = sample;
		@(negedge clk);
		tick     = 1'b0;
		last_out = sample_out;
		compare_value("sample_out", sample_out, expected);
		for (int i = 1; i < gap + pause_len; i++) begin
			if (pause_len > 0 && i == pause_at)
				enable = 1'b0;
			if (pause_len > 0 && i == pause_at + pause_len)
				enable = 1'b1;
			@(negedge clk);
		end
	endtask

	// ********************
	// Test sequence
	// ********************

	initial begin
		logic signed [15:0] s;
		int                 pause_at;
		lfsr_state              = 32'h8432_fa41;
		check_count             = 0;
		error_count             = 0;
		full_reset              = 1'b1;
		enable                  = 1'b1;
		tick                    = 1'b0;
		sample_in               = '0;
		command_instr_write     = 1'b0;
		command_reg_write       = 1'b0;
		command_block_target    = '0;
		command_reg_target      = 1'b0;
		command_instr_write_val = '0;
		command_reg_write_val   = '0;
		@(negedge clk);

		// Empty program, so samples only pass through channel 0.
		apply_reset();
		random_coefs();
		s = 16'(random_bits(16));
		tick_and_check(s, 0, 0);
		compare_value("sample_out", last_out, 16'h0000);
		tick_and_check(16'(random_bits(16)), 0, 0);
		compare_value("sample_out", last_out, s);

		// Saturation and wrap with one block.
		write_coef(4'd0, 1'b0, 16'sh7fff);
		write_coef(4'd0, 1'b1, 16'sh7fff);
		write_instr(4'd0, reg_madd(4'd0, 4'd1, 4'd2, 1'b0));
		repeat (2) tick_and_check(16'(random_bits(16)), 0, 0);
		compare_value("sample_out", last_out, 16'h7fff);
		write_instr(4'd0, reg_madd(4'd3, 4'd0, 4'd3, 1'b0));
		repeat (2) tick_and_check(16'(random_bits(16)), 0, 0);
		compare_value("sample_out", last_out, 16'h8000);
		write_instr(4'd0, reg_madd(4'd0, 4'd1, 4'd2, 1'b1));
		repeat (2) tick_and_check(16'(random_bits(16)), 0, 0);
		compare_value("sample_out", last_out, 16'h3ffc);

		for (int p = 0; p < n_rand_programs; p++) begin
			random_coefs();
			repeat (1 + random_bits(3)) write_instr(4'(random_bits(4)), random_instr());
			repeat (ticks_per_program) tick_and_check(16'(random_bits(16)), 0, 0);
		end

		for (int p = 0; p < n_pause_programs; p++) begin
			repeat (1 + random_bits(2)) write_instr(4'(random_bits(4)), random_instr());
			repeat (ticks_per_program) begin
				pause_at = 1 + int'(random_bits(8)) % (5 * model_running);
				tick_and_check(16'(random_bits(16)), pause_at, 1 + int'(random_bits(4)));
			end
		end

		// Clear a loaded program, then reuse the old coefficients.
		apply_reset();
		s = 16'(random_bits(16));
		tick_and_check(s, 0, 0);
		compare_value("sample_out", last_out, 16'h0000);
		tick_and_check(16'(random_bits(16)), 0, 0);
		compare_value("sample_out", last_out, s);
		repeat (2) write_instr(4'(random_bits(2)), random_instr());
		write_instr(4'd0, reg_madd(4'd0, 4'd1, 4'd2, 1'b0));
		repeat (6) tick_and_check(16'(random_bits(16)), 0, 0);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout: the tests did not finish within %0d clock cycles.", watchdog_cycles);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
